// ==== rtl/z88_kbd_pkg.sv ====
package z88_kbd_pkg;

  typedef logic [7:0]  scan_code_t;
  typedef logic [5:0]  key_index_t;
  typedef logic [7:0]  kb_row_t;
  typedef logic [63:0] kb_matrix_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_e;

  typedef enum logic [1:0] {
    DEC_BASE,
    DEC_BREAK,
    DEC_EXT,
    DEC_EXT_BREAK
  } dec_state_e;

  localparam scan_code_t SC_BREAK = 8'hF0;
  localparam scan_code_t SC_EXT   = 8'hE0;

  // Set-2 code per matrix position, one Z88 row per line, column 0 first
  // Rows A8..A15, keypad arrows stand in for the cursor keys
  localparam scan_code_t KEY_CODES [0:63] = '{
    8'h3E, 8'h3D, 8'h31, 8'h33, 8'h35, 8'h36, 8'h5A, 8'h66,
    8'h43, 8'h3C, 8'h32, 8'h34, 8'h2C, 8'h2E, 8'h75, 8'h5D,
    8'h44, 8'h3B, 8'h2A, 8'h2B, 8'h2D, 8'h25, 8'h72, 8'h55,
    8'h46, 8'h42, 8'h21, 8'h23, 8'h24, 8'h26, 8'h74, 8'h4E,
    8'h4D, 8'h3A, 8'h22, 8'h1B, 8'h1D, 8'h1E, 8'h6B, 8'h5B,
    8'h45, 8'h4B, 8'h1A, 8'h1C, 8'h15, 8'h16, 8'h29, 8'h54,
    8'h52, 8'h4C, 8'h41, 8'h06, 8'h14, 8'h0D, 8'h12, 8'h05,
    8'h0E, 8'h4A, 8'h49, 8'h58, 8'h04, 8'h76, 8'h11, 8'h59
  };

  // Returns 1 when the code is mapped, idx then holds row*8+column
  function automatic logic key_lookup(input scan_code_t code, output key_index_t idx);
    logic hit;
    hit = 1'b0;
    idx = '0;
    for (int i = 0; i < 64; i++) begin
      if (!hit && KEY_CODES[i] == code) begin
        hit = 1'b1;
        idx = key_index_t'(i);
      end
    end
    return hit;
  endfunction

endpackage

// ==== rtl/ps2_rx.sv ====
`timescale 1ns/1ps

module ps2_rx #(
  parameter int TIMEOUT_CYCLES = 2000
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    ps2clk,
  input  logic                    ps2dat,
  output z88_kbd_pkg::scan_code_t code,
  output logic                    code_valid,
  output logic                    frame_err
);
  import z88_kbd_pkg::*;

  localparam int TW = $clog2(TIMEOUT_CYCLES + 1);

  logic [1:0]    clk_sync;
  logic [1:0]    dat_sync;
  logic          clk_prev;
  logic          clk_fall;
  logic          dat_bit;
  rx_state_e     state;
  logic [2:0]    bit_cnt;
  scan_code_t    shift_q;
  logic          parity_ok;
  logic [TW-1:0] idle_cnt;
  logic          timeout;

  // Two-flop synchronisers, idle level of both lines is high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clk_sync <= 2'b11;
      dat_sync <= 2'b11;
      clk_prev <= 1'b1;
    end else begin
      clk_sync <= {clk_sync[0], ps2clk};
      dat_sync <= {dat_sync[0], ps2dat};
      clk_prev <= clk_sync[1];
    end
  end

  assign clk_fall = clk_prev & ~clk_sync[1];
  assign dat_bit  = dat_sync[1];
  assign timeout  = (idle_cnt == TW'(TIMEOUT_CYCLES));
  assign code     = shift_q;

  // Frame sequencing and idle watchdog
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= RX_IDLE;
      bit_cnt    <= '0;
      idle_cnt   <= '0;
      code_valid <= 1'b0;
      frame_err  <= 1'b0;
    end else begin
      code_valid <= 1'b0;
      frame_err  <= 1'b0;
      if (clk_fall) begin
        idle_cnt <= '0;
        case (state)
          RX_IDLE: begin
            // Start bit must be low, a high sample is a glitch
            if (!dat_bit) begin
              state   <= RX_DATA;
              bit_cnt <= '0;
            end
          end
          RX_DATA: begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
              state <= RX_PARITY;
            end
          end
          RX_PARITY: begin
            state <= RX_STOP;
          end
          RX_STOP: begin
            state <= RX_IDLE;
            if (dat_bit && parity_ok) begin
              code_valid <= 1'b1;
            end else begin
              frame_err <= 1'b1;
            end
          end
          default: begin
            state <= RX_IDLE;
          end
        endcase
      end else if (state != RX_IDLE) begin
        if (timeout) begin
          // Keyboard went quiet mid-frame, drop it
          state    <= RX_IDLE;
          idle_cnt <= '0;
        end else begin
          idle_cnt <= idle_cnt + TW'(1);
        end
      end
    end
  end

  // Data shifts in LSB first, odd parity over data and parity bit
  always_ff @(posedge clk) begin
    if (clk_fall) begin
      if (state == RX_DATA) begin
        shift_q <= {dat_bit, shift_q[7:1]};
      end
      if (state == RX_PARITY) begin
        parity_ok <= ^{shift_q, dat_bit};
      end
    end
  end

endmodule

// ==== rtl/scan_decoder.sv ====
`timescale 1ns/1ps

module scan_decoder (
  input  logic                    clk,
  input  logic                    rst_n,
  input  z88_kbd_pkg::scan_code_t code,
  input  logic                    code_valid,
  output logic                    key_valid,
  output z88_kbd_pkg::key_index_t key_idx,
  output logic                    key_down
);
  import z88_kbd_pkg::*;

  dec_state_e state;
  logic       is_break;
  logic       is_ext;
  logic       lut_hit;
  key_index_t lut_idx;

  assign is_break = (code == SC_BREAK);
  assign is_ext   = (code == SC_EXT);

  always_comb begin
    lut_hit = key_lookup(code, lut_idx);
  end

  // Prefix tracking, one event per ordinary byte in base or break state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= DEC_BASE;
      key_valid <= 1'b0;
    end else begin
      key_valid <= 1'b0;
      if (code_valid) begin
        case (state)
          DEC_BASE: begin
            if (is_break) begin
              state <= DEC_BREAK;
            end else if (is_ext) begin
              state <= DEC_EXT;
            end else begin
              key_valid <= lut_hit;
            end
          end
          DEC_BREAK: begin
            if (is_ext) begin
              state <= DEC_EXT_BREAK;
            end else if (!is_break) begin
              key_valid <= lut_hit;
              state     <= DEC_BASE;
            end
          end
          DEC_EXT: begin
            // Extended keys are not on the Z88 matrix
            if (is_break) begin
              state <= DEC_EXT_BREAK;
            end else if (!is_ext) begin
              state <= DEC_BASE;
            end
          end
          DEC_EXT_BREAK: begin
            if (!is_break && !is_ext) begin
              state <= DEC_BASE;
            end
          end
          default: begin
            state <= DEC_BASE;
          end
        endcase
      end
    end
  end

  // Event payload, only looked at while key_valid is high
  always_ff @(posedge clk) begin
    if (code_valid) begin
      key_idx  <= lut_idx;
      key_down <= (state == DEC_BASE);
    end
  end

endmodule

// ==== rtl/kb_matrix_regs.sv ====
`timescale 1ns/1ps

module kb_matrix_regs (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    key_valid,
  input  z88_kbd_pkg::key_index_t key_idx,
  input  logic                    key_down,
  input  z88_kbd_pkg::kb_row_t    row_sel,
  output z88_kbd_pkg::kb_matrix_t kbmat_out,
  output z88_kbd_pkg::kb_row_t    kb_col
);
  import z88_kbd_pkg::*;

  kb_matrix_t matrix;
  kb_row_t    rows [0:7];

  // Active low, a cleared bit is a pressed key
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      matrix <= '1;
    end else if (key_valid) begin
      matrix[key_idx] <= ~key_down;
    end
  end

  // Row r lives in bits 8r+7..8r
  always_comb begin
    for (int r = 0; r < 8; r++) begin
      rows[r] = matrix[r*8 +: 8];
    end
  end

  // Keyboard port read, every selected row pulls its columns low
  always_comb begin
    kb_col = '1;
    for (int r = 0; r < 8; r++) begin
      if (!row_sel[r]) begin
        kb_col = kb_col & rows[r];
      end
    end
  end

  assign kbmat_out = matrix;

endmodule

// ==== rtl/z88_kbd.sv ====
`timescale 1ns/1ps

module z88_kbd #(
  parameter int TIMEOUT_CYCLES = 2000
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    ps2clk,
  input  logic                    ps2dat,
  input  z88_kbd_pkg::kb_row_t    row_sel,
  output z88_kbd_pkg::kb_matrix_t kbmat_out,
  output z88_kbd_pkg::kb_row_t    kb_col,
  output logic                    frame_err
);
  import z88_kbd_pkg::*;

  // Receiver to decoder
  scan_code_t code;
  logic       code_valid;

  // Decoder to matrix
  logic       key_valid;
  key_index_t key_idx;
  logic       key_down;

  ps2_rx #(
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES)
  ) ps2_rx_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .ps2clk    (ps2clk),
    .ps2dat    (ps2dat),
    .code      (code),
    .code_valid(code_valid),
    .frame_err (frame_err)
  );

  scan_decoder scan_decoder_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .code      (code),
    .code_valid(code_valid),
    .key_valid (key_valid),
    .key_idx   (key_idx),
    .key_down  (key_down)
  );

  kb_matrix_regs kb_matrix_regs_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .key_valid(key_valid),
    .key_idx  (key_idx),
    .key_down (key_down),
    .row_sel  (row_sel),
    .kbmat_out(kbmat_out),
    .kb_col   (kb_col)
  );

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter real PERIOD_NS    = 4.0,
  parameter int  RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) clk = ~clk;
    end
  end

  // Reset released on a rising edge once the hold time has passed
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== test/tb_z88_kbd.sv ====
`timescale 1ns/1ps

module tb_z88_kbd;

  localparam int     HALF_BIT    = 10;
  localparam int     NUM_OPS     = 300;
  localparam longint WATCHDOG_NS = 64'd2000 * 64'd300 * 64'd4;

  // Set-2 code for each matrix position, row*8+column
  localparam logic [7:0] CODES [0:63] = '{
    8'h3E, 8'h3D, 8'h31, 8'h33, 8'h35, 8'h36, 8'h5A, 8'h66,
    8'h43, 8'h3C, 8'h32, 8'h34, 8'h2C, 8'h2E, 8'h75, 8'h5D,
    8'h44, 8'h3B, 8'h2A, 8'h2B, 8'h2D, 8'h25, 8'h72, 8'h55,
    8'h46, 8'h42, 8'h21, 8'h23, 8'h24, 8'h26, 8'h74, 8'h4E,
    8'h4D, 8'h3A, 8'h22, 8'h1B, 8'h1D, 8'h1E, 8'h6B, 8'h5B,
    8'h45, 8'h4B, 8'h1A, 8'h1C, 8'h15, 8'h16, 8'h29, 8'h54,
    8'h52, 8'h4C, 8'h41, 8'h06, 8'h14, 8'h0D, 8'h12, 8'h05,
    8'h0E, 8'h4A, 8'h49, 8'h58, 8'h04, 8'h76, 8'h11, 8'h59
  };

  logic        clk;
  logic        rst_n;
  logic        ps2clk;
  logic        ps2dat;
  logic [7:0]  row_sel;
  logic [63:0] kbmat_out;
  logic [7:0]  kb_col;
  logic        frame_err;

  // Expected matrix, active low like the DUT
  logic [63:0] model;
  int          bad_frames;
  int          err_pulses;

  tb_clock #(
    .PERIOD_NS   (4.0),
    .RESET_CYCLES(2)
  ) tb_clock_i (
    .clk  (clk),
    .rst_n(rst_n)
  );

  z88_kbd #(
    .TIMEOUT_CYCLES(200)
  ) z88_kbd_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .ps2clk   (ps2clk),
    .ps2dat   (ps2dat),
    .row_sel  (row_sel),
    .kbmat_out(kbmat_out),
    .kb_col   (kb_col),
    .frame_err(frame_err)
  );

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_pulses <= 0;
    end else if (frame_err) begin
      err_pulses <= err_pulses + 1;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the test sequence finished");
    $display("tests failed");
    $fatal(1, "simulation timed out");
  end

  task automatic check(input string name, input logic [63:0] actual,
                       input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("tests failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  // Port read: AND of every row whose select bit is low
  function automatic logic [7:0] col_model(input logic [63:0] mat, input logic [7:0] sel);
    logic [7:0] col;
    col = 8'hFF;
    for (int r = 0; r < 8; r++) begin
      if (!sel[0]) begin
        col = col & mat[7:0];
      end
      mat = mat >> 8;
      sel = sel >> 1;
    end
    return col;
  endfunction

  function automatic logic is_mapped(input logic [7:0] data);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < 64; i++) begin
      if (CODES[i[5:0]] == data) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // Bits go out LSB first, data changes while the PS/2 clock is high
  task automatic drive_bits(input logic [10:0] bits, input int count);
    @(posedge clk);
    for (int i = 0; i < count; i++) begin
      ps2dat <= bits[0];
      bits = bits >> 1;
      repeat (HALF_BIT) @(posedge clk);
      ps2clk <= 1'b0;
      repeat (HALF_BIT) @(posedge clk);
      ps2clk <= 1'b1;
    end
    ps2dat <= 1'b1;
  endtask

  task automatic send_byte(input logic [7:0] data, input logic bad_parity,
                           input logic bad_stop);
    logic [10:0] bits;
    bits = {~bad_stop, (~^data) ^ bad_parity, data, 1'b0};
    drive_bits(bits, 11);
  endtask

  task automatic settle_and_check();
    repeat (20) @(posedge clk);
    row_sel <= 8'($urandom);
    @(negedge clk);
    check("kbmat_out", kbmat_out, model);
    check("kb_col", 64'(kb_col), 64'(col_model(model, row_sel)));
    check("frame_err count", 64'(err_pulses), 64'(bad_frames));
  endtask

  task automatic send_and_check(input logic [7:0] data);
    send_byte(data, 1'b0, 1'b0);
    settle_and_check();
  endtask

  // Press a released key, or release a pressed one with F0
  task automatic key_event();
    logic [5:0] idx;
    idx = 6'($urandom_range(0, 63));
    if (model[idx]) begin
      model[idx] = 1'b0;
      send_and_check(CODES[idx]);
    end else begin
      send_and_check(8'hF0);
      model[idx] = 1'b1;
      send_and_check(CODES[idx]);
    end
  endtask

  initial begin
    int         op;
    int         nbits;
    logic [7:0] data;
    void'($urandom(34));
    ps2clk     <= 1'b1;
    ps2dat     <= 1'b1;
    row_sel    <= 8'hFF;
    model      = '1;
    bad_frames = 0;
    @(posedge rst_n);
    repeat (4) @(posedge clk);
    @(negedge clk);
    check("kbmat_out", kbmat_out, model);
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      row_sel <= 8'($urandom);
      @(negedge clk);
      check("kb_col", 64'(kb_col), 64'hFF);
    end
    for (int n = 0; n < NUM_OPS; n++) begin
      op = int'($urandom_range(0, 9));
      case (op)
        5, 6: begin
          // Corrupt parity or stop bit
          data = 8'($urandom);
          bad_frames = bad_frames + 1;
          send_byte(data, op == 5, op == 6);
          settle_and_check();
          key_event();
        end
        7: begin
          data = CODES[6'($urandom_range(0, 63))];
          send_and_check(8'hE0);
          if ($urandom_range(0, 1) == 1) begin
            send_and_check(8'hF0);
          end
          send_and_check(data);
          key_event();
        end
        8: begin
          do begin
            data = 8'($urandom);
          end while (is_mapped(data) || data == 8'hE0 || data == 8'hF0);
          send_and_check(data);
          key_event();
        end
        9: begin
          // Partial frame, then long enough idle for the receiver to drop it
          nbits = int'($urandom_range(1, 9));
          data  = 8'($urandom);
          drive_bits({1'b1, ~^data, data, 1'b0}, nbits);
          repeat (250) @(posedge clk);
          settle_and_check();
          key_event();
        end
        default: begin
          key_event();
        end
      endcase
    end
    $display("all tests passed");
    $finish;
  end

endmodule

// ==== compile.f ====
rtl/z88_kbd_pkg.sv
rtl/ps2_rx.sv
rtl/scan_decoder.sv
rtl/kb_matrix_regs.sv
rtl/z88_kbd.sv
test/tb_clock.sv
test/tb_z88_kbd.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the keyboard testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_z88_kbd -f compile.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_z88_kbd > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulator exited with status $run_status"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
